//--- project.f
rtl/peDecodePkg.sv
rtl/predicateGate.sv
rtl/writebackReg.sv
rtl/aluIssue.sv
rtl/mslIssue.sv
rtl/peDecode.sv
bench/peDecodeTb.sv

//--- run.sh
#!/bin/sh
# Build and run the PE decode testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f project.f \
  --top-module peDecodeTb -o peDecodeSim

out=$(./obj_dir/peDecodeSim 2>&1 || true)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi

//--- bench/peDecodeTb.sv
// Testbench for the PE decode stage
// Applies a table of instructions on the falling edge and checks isSub in
// the same cycle and the EX-side registers one rising edge later
`timescale 1ns/100ps
`default_nettype none

module peDecodeTb
  import peDecodePkg::*;
();

  localparam int dataWidth    = defDataWidth;
  localparam int rfIndexWidth = defRfIndexWidth;
  localparam int clkPeriod    = 100;
  localparam int halfPeriod   = clkPeriod / 2;

  // DUT inputs
  logic                    iClk = 1'b0;
  logic                    rstN;
  predT                    predCode;
  logic [rfIndexWidth-1:0] rfAddr;
  wbSrcT                   wbSrc;
  aluOpT                   aluOp;
  updSelT                  updSel;
  mslOpT                   mslOp;
  logic                    p0, p1, rfWe, isAlu, isMsl, isMul, isShift;
  logic [dataWidth-1:0]    opA, opB;
  // DUT outputs
  logic                    isSub, exWbEn, exUpdFlag, exUpdP0, exUpdP1, exIsMul, exIsShift;
  logic [rfIndexWidth-1:0] exRfAddr;
  wbSrcT                   exWbSrc;
  aluOpT                   exAluOp;
  mslOpT                   exMslOp;
  logic [dataWidth-1:0]    exAluA, exAluB, exMslA, exMslB;

  // One instruction and what EX sees after it
  typedef struct {
    string                   name;
    predT                    pred;
    logic                    p0, p1, rfWe, isAlu, isMsl, isMul, isShift;
    logic [rfIndexWidth-1:0] rfAddr;
    wbSrcT                   wbSrc;
    aluOpT                   aluOp;
    updSelT                  updSel;
    mslOpT                   mslOp;
    logic [dataWidth-1:0]    a, b;
    logic                    wbEn, sub;       // sub checked before the edge
    logic [rfIndexWidth-1:0] xAddr;
    wbSrcT                   xSrc;
    aluOpT                   xAluOp;
    mslOpT                   xMslOp;
    logic [dataWidth-1:0]    xAluA, xAluB, xMslA, xMslB;
    logic [2:0]              xUpd;            // Flag, P0, P1
    logic [1:0]              xKind;           // Mul, shift
  } rowT;

  rowT                  rows[$];
  rowT                  cur;                  // Row under construction
  integer               seed;
  logic [dataWidth-1:0] rA, rB, rC, rD;       // Random operands

  peDecode #(.dataWidth(dataWidth), .rfIndexWidth(rfIndexWidth)) peDecode_i (
    .iClk (iClk), .rstN (rstN),
    .predCode (predCode), .rfAddr (rfAddr), .rfWe (rfWe), .wbSrc (wbSrc),
    .aluOp (aluOp), .isAlu (isAlu), .updSel (updSel),
    .mslOp (mslOp), .isMsl (isMsl), .isMul (isMul), .isShift (isShift),
    .p0 (p0), .p1 (p1), .opA (opA), .opB (opB), .isSub (isSub),
    .exWbEn (exWbEn), .exRfAddr (exRfAddr), .exWbSrc (exWbSrc),
    .exAluOp (exAluOp), .exAluA (exAluA), .exAluB (exAluB),
    .exUpdFlag (exUpdFlag), .exUpdP0 (exUpdP0), .exUpdP1 (exUpdP1),
    .exMslOp (exMslOp), .exMslA (exMslA), .exMslB (exMslB),
    .exIsMul (exIsMul), .exIsShift (exIsShift)
  );

  always #halfPeriod iClk = ~iClk;  // 100 ns period

  // ********************************************************
  // Table helpers
  // ********************************************************
  // Row inputs for predicate, write-back, ALU, MSL and operands
  task automatic setStim(
    input predT pc, input logic pp0, input logic pp1,
    input logic we, input logic [rfIndexWidth-1:0] ad, input wbSrcT src,
    input logic al, input aluOpT aop, input updSelT us,
    input logic ms, input mslOpT mop, input logic mu, input logic sh,
    input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b
  );
    cur.pred   = pc;
    cur.p0     = pp0;
    cur.p1     = pp1;
    cur.rfWe   = we;
    cur.rfAddr = ad;
    cur.wbSrc  = src;
    cur.isAlu  = al;
    cur.aluOp  = aop;
    cur.updSel = us;
    cur.isMsl  = ms;
    cur.mslOp  = mop;
    cur.isMul  = mu;
    cur.isShift = sh;
    cur.a      = a;
    cur.b      = b;
  endtask

  // Expected EX state before the row joins the table
  task automatic addRow(
    input string nm, input logic en, input logic [rfIndexWidth-1:0] ad, input wbSrcT src,
    input aluOpT aop, input logic [dataWidth-1:0] aa, input logic [dataWidth-1:0] ab,
    input logic [2:0] upd, input mslOpT mop, input logic [dataWidth-1:0] ma,
    input logic [dataWidth-1:0] mb, input logic [1:0] kind, input logic sub
  );
    cur.name   = nm;
    cur.wbEn   = en;
    cur.xAddr  = ad;
    cur.xSrc   = src;
    cur.xAluOp = aop;
    cur.xAluA  = aa;
    cur.xAluB  = ab;
    cur.xUpd   = upd;
    cur.xMslOp = mop;
    cur.xMslA  = ma;
    cur.xMslB  = mb;
    cur.xKind  = kind;
    cur.sub    = sub;
    rows.push_back(cur);
  endtask

  // Predicated ALU op writing R6 from LR with its result to the flag
  task automatic predRow(
    input predT pc, input logic pp0, input logic pp1, input aluOpT aop,
    input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b, input logic ok,
    input aluOpT xop, input logic [dataWidth-1:0] xa, input logic [dataWidth-1:0] xb,
    input logic sub
  );
    setStim(pc, pp0, pp1, 1, 6, srcLr, 1, aop, updFlag, 0, mslNop, 0, 0, a, b);
    addRow($sformatf("pred %s p%0d%0d", pc.name(), pp0, pp1), ok, 6, srcLr, xop, xa, xb,
           {ok, 2'b00}, mslNop, 0, 0, 2'b00, sub);
  endtask

  // ********************************************************
  // Stimulus table
  // ********************************************************
  task automatic buildTable();
    // First row matches the reset values too
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 0, aluNop, updFlag, 0, mslNop, 0, 0, 0, 0);
    addRow("idle", 0, 0, srcAlu, aluNop, 0, 0, 3'b000, mslNop, 0, 0, 2'b00, 0);
    // All codes under every P0/P1 pair with failing rows holding the ALU regs
    predRow(predAlways, 0, 0, aluAdd, 24'h101, 24'h201, 1, aluAdd, 24'h101, 24'h201, 0);
    predRow(predOnP0,   0, 0, aluSub, 24'h102, 24'h202, 0, aluAdd, 24'h101, 24'h201, 0);
    predRow(predOnP1,   0, 0, aluSub, 24'h103, 24'h203, 0, aluAdd, 24'h101, 24'h201, 0);
    predRow(predOnBoth, 0, 0, aluAdd, 24'h104, 24'h204, 0, aluAdd, 24'h101, 24'h201, 0);
    predRow(predAlways, 1, 0, aluSub, 24'h105, 24'h205, 1, aluSub, 24'h105, 24'h205, 1);
    predRow(predOnP0,   1, 0, aluAdd, 24'h106, 24'h206, 1, aluAdd, 24'h106, 24'h206, 0);
    predRow(predOnP1,   1, 0, aluSub, 24'h107, 24'h207, 0, aluAdd, 24'h106, 24'h206, 0);
    predRow(predOnBoth, 1, 0, aluAdd, 24'h108, 24'h208, 0, aluAdd, 24'h106, 24'h206, 0);
    predRow(predAlways, 0, 1, aluAdd, 24'h109, 24'h209, 1, aluAdd, 24'h109, 24'h209, 0);
    predRow(predOnP0,   0, 1, aluSub, 24'h10a, 24'h20a, 0, aluAdd, 24'h109, 24'h209, 0);
    predRow(predOnP1,   0, 1, aluSub, 24'h10b, 24'h20b, 1, aluSub, 24'h10b, 24'h20b, 1);
    predRow(predOnBoth, 0, 1, aluAdd, 24'h10c, 24'h20c, 0, aluSub, 24'h10b, 24'h20b, 0);
    predRow(predAlways, 1, 1, aluAdd, 24'h10d, 24'h20d, 1, aluAdd, 24'h10d, 24'h20d, 0);
    predRow(predOnP0,   1, 1, aluAdd, 24'h10e, 24'h20e, 1, aluAdd, 24'h10e, 24'h20e, 0);
    predRow(predOnP1,   1, 1, aluAdd, 24'h10f, 24'h20f, 1, aluAdd, 24'h10f, 24'h20f, 0);
    predRow(predOnBoth, 1, 1, aluSub, 24'h110, 24'h210, 1, aluSub, 24'h110, 24'h210, 1);
    // Write-back to R0, a real write and then no write
    setStim(predAlways, 0, 0, 1, 0, srcMul, 0, aluNop, updFlag, 0, mslNop, 0, 0, 24'h81, 24'h82);
    addRow("wb r0", 0, 6, srcLr, aluSub, 24'h110, 24'h210, 3'b000, mslNop, 0, 0, 2'b00, 0);
    setStim(predAlways, 0, 0, 1, 9, srcLsu, 0, aluNop, updFlag, 0, mslNop, 0, 0, 24'h83, 24'h84);
    addRow("wb r9", 1, 9, srcLsu, aluSub, 24'h110, 24'h210, 3'b000, mslNop, 0, 0, 2'b00, 0);
    setStim(predAlways, 0, 0, 0, 3, srcAlu, 0, aluNop, updFlag, 0, mslNop, 0, 0, 24'h85, 24'h86);
    addRow("wb none", 0, 9, srcLsu, aluSub, 24'h110, 24'h210, 3'b000, mslNop, 0, 0, 2'b00, 0);
    // Compare routing with the spare code going to the flag
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 1, aluCmpEq, updFlag, 0, mslNop, 0, 0, rA, rB);
    addRow("upd flag", 0, 9, srcLsu, aluCmpEq, rA, rB, 3'b100, mslNop, 0, 0, 2'b00, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 1, aluCmpLt, updP0, 0, mslNop, 0, 0, 24'h31, 24'h32);
    addRow("upd p0", 0, 9, srcLsu, aluCmpLt, 24'h31, 24'h32, 3'b010, mslNop, 0, 0, 2'b00, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 1, aluCmpEq, updP1, 0, mslNop, 0, 0, 24'h33, 24'h34);
    addRow("upd p1", 0, 9, srcLsu, aluCmpEq, 24'h33, 24'h34, 3'b001, mslNop, 0, 0, 2'b00, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 1, aluCmpLt, updRsvd, 0, mslNop, 0, 0, 24'h35, 24'h36);
    addRow("upd spare", 0, 9, srcLsu, aluCmpLt, 24'h35, 24'h36, 3'b100, mslNop, 0, 0, 2'b00, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 0, aluNop, updP0, 0, mslNop, 0, 0, 24'h37, 24'h38);
    addRow("no alu", 0, 9, srcLsu, aluCmpLt, 24'h35, 24'h36, 3'b000, mslNop, 0, 0, 2'b00, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 1, aluSub, updFlag, 0, mslNop, 0, 0, 24'h41, 24'h42);
    addRow("sub", 0, 9, srcLsu, aluSub, 24'h41, 24'h42, 3'b100, mslNop, 0, 0, 2'b00, 1);
    // MSL issue with ALU rows in between
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 0, aluNop, updFlag, 1, mslMul, 1, 0, rC, rD);
    addRow("mul", 0, 9, srcLsu, aluSub, 24'h41, 24'h42, 3'b000, mslMul, rC, rD, 2'b10, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 1, aluAdd, updP1, 0, mslNop, 0, 0, 24'h51, 24'h52);
    addRow("alu mid", 0, 9, srcLsu, aluAdd, 24'h51, 24'h52, 3'b001, mslMul, rC, rD, 2'b10, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 0, aluNop, updFlag, 1, mslShl, 0, 1, 24'h61, 24'h62);
    addRow("shl", 0, 9, srcLsu, aluAdd, 24'h51, 24'h52, 3'b000, mslShl, 24'h61, 24'h62, 2'b01, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 1, aluCmpEq, updP0, 0, mslNop, 0, 0, 24'h53, 24'h54);
    addRow("alu mid2", 0, 9, srcLsu, aluCmpEq, 24'h53, 24'h54, 3'b010, mslShl, 24'h61, 24'h62,
           2'b01, 0);
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 0, aluNop, updFlag, 1, mslXor, 0, 0, 24'h63, 24'h64);
    addRow("xor", 0, 9, srcLsu, aluCmpEq, 24'h53, 24'h54, 3'b000, mslXor, 24'h63, 24'h64, 2'b00, 0);
    // Back-to-back ALU, MSL, squashed, sub and logic rows
    setStim(predAlways, 0, 0, 1, 2, srcAlu, 1, aluAdd, updFlag, 0, mslNop, 0, 0, 24'h71, 24'h72);
    addRow("b2b alu", 1, 2, srcAlu, aluAdd, 24'h71, 24'h72, 3'b100, mslXor, 24'h63, 24'h64,
           2'b00, 0);
    setStim(predAlways, 0, 0, 1, 3, srcMul, 0, aluNop, updFlag, 1, mslShr, 0, 1, 24'h73, 24'h74);
    addRow("b2b msl", 1, 3, srcMul, aluAdd, 24'h71, 24'h72, 3'b000, mslShr, 24'h73, 24'h74,
           2'b01, 0);
    setStim(predOnBoth, 1, 0, 1, 4, srcLr, 0, aluNop, updFlag, 1, mslMul, 1, 0, 24'h75, 24'h76);
    addRow("b2b off", 0, 3, srcMul, aluAdd, 24'h71, 24'h72, 3'b000, mslShr, 24'h73, 24'h74,
           2'b01, 0);
    setStim(predOnP0, 1, 0, 1, 7, srcAlu, 1, aluSub, updP1, 0, mslNop, 0, 0, 24'h77, 24'h78);
    addRow("b2b sub", 1, 7, srcAlu, aluSub, 24'h77, 24'h78, 3'b001, mslShr, 24'h73, 24'h74,
           2'b01, 1);
    setStim(predAlways, 1, 0, 0, 0, srcAlu, 0, aluNop, updFlag, 1, mslAnd, 0, 0, 24'h79, 24'h7a);
    addRow("b2b and", 0, 7, srcAlu, aluSub, 24'h77, 24'h78, 3'b000, mslAnd, 24'h79, 24'h7a,
           2'b00, 0);
  endtask

  // ********************************************************
  // Drive and check
  // ********************************************************
  task automatic driveRow(input rowT r);
    predCode = r.pred;
    p0       = r.p0;
    p1       = r.p1;
    rfWe     = r.rfWe;
    rfAddr   = r.rfAddr;
    wbSrc    = r.wbSrc;
    isAlu    = r.isAlu;
    aluOp    = r.aluOp;
    updSel   = r.updSel;
    isMsl    = r.isMsl;
    mslOp    = r.mslOp;
    isMul    = r.isMul;
    isShift  = r.isShift;
    opA      = r.a;
    opB      = r.b;
  endtask

  task automatic checkVal(input string test, input string what,
                          input logic [31:0] expVal, input logic [31:0] actVal);
    if (actVal !== expVal)
    begin
      $display("ERR %s %s: expected %0h actual %0h", test, what, expVal, actVal);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // Registered EX outputs grouped by block
  task automatic checkOuts(input rowT r, input string test);
    checkVal(test, "wb en/addr/src", 32'({r.wbEn, r.xAddr, r.xSrc}),
             32'({exWbEn, exRfAddr, exWbSrc}));
    checkVal(test, "exAluOp", 32'(r.xAluOp), 32'(exAluOp));
    checkVal(test, "exAluA", 32'(r.xAluA), 32'(exAluA));
    checkVal(test, "exAluB", 32'(r.xAluB), 32'(exAluB));
    checkVal(test, "upd flag/p0/p1", 32'(r.xUpd), 32'({exUpdFlag, exUpdP0, exUpdP1}));
    checkVal(test, "exMslOp", 32'(r.xMslOp), 32'(exMslOp));
    checkVal(test, "exMslA", 32'(r.xMslA), 32'(exMslA));
    checkVal(test, "exMslB", 32'(r.xMslB), 32'(exMslB));
    checkVal(test, "mul/shift", 32'(r.xKind), 32'({exIsMul, exIsShift}));
  endtask

  // ********************************************************
  // Main sequence
  // ********************************************************
  initial
  begin
    seed = 32'he280;
    rA   = 24'($random(seed));
    rB   = 24'($random(seed));
    rC   = 24'($random(seed));
    rD   = 24'($random(seed));
    setStim(predAlways, 0, 0, 0, 0, srcAlu, 0, aluNop, updFlag, 0, mslNop, 0, 0, 0, 0);
    driveRow(cur);  // Idle inputs
    rstN = 1'b0;
    buildTable();
    repeat (16) @(posedge iClk);
    @(negedge iClk);
    rstN = 1'b1;
    #10;
    checkOuts(rows[0], "reset");  // Idle row expects reset values
    for (int i = 0; i < rows.size(); i++)
    begin
      @(negedge iClk);
      if (i > 0)
        checkOuts(rows[i-1], rows[i-1].name);  // Loaded at the last rising edge
      driveRow(rows[i]);
      #10;
      checkVal(rows[i].name, "isSub", 32'(rows[i].sub), 32'(isSub));  // Same cycle
    end
    @(negedge iClk);
    checkOuts(rows[rows.size()-1], rows[rows.size()-1].name);
    $display("*** PASSED ***");
    $finish;
  end

  // Watchdog sized from reset plus table length
  initial
  begin
    #1;
    #((16 + rows.size() + 10) * clkPeriod);
    $display("Watchdog expired before the table finished");
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

//--- rtl/peDecode.sv
// PE instruction-decode stage, second half
// Predicates the first-half controls and registers write-back, ALU
// and multiply/shift/logic controls and operands for the EX stage
`timescale 1ns/100ps
`default_nettype none

module peDecode
  import peDecodePkg::*;
#(
  parameter int dataWidth    = defDataWidth,
  parameter int rfIndexWidth = defRfIndexWidth
)
(
  input  wire                    iClk,
  input  wire                    rstN,
  // First decode half
  input  var predT               predCode,
  input  wire [rfIndexWidth-1:0] rfAddr,
  input  wire                    rfWe,
  input  var wbSrcT              wbSrc,
  input  var aluOpT              aluOp,
  input  wire                    isAlu,
  input  var updSelT             updSel,
  input  var mslOpT              mslOp,
  input  wire                    isMsl,
  input  wire                    isMul,
  input  wire                    isShift,
  // EX stage predicate regs
  input  wire                    p0,
  input  wire                    p1,
  // Bypass network
  input  wire [dataWidth-1:0]    opA,
  input  wire [dataWidth-1:0]    opB,
  output logic                   isSub,
  // To EX
  output logic                   exWbEn,
  output logic [rfIndexWidth-1:0] exRfAddr,
  output wbSrcT                  exWbSrc,
  output aluOpT                  exAluOp,
  output logic [dataWidth-1:0]   exAluA,
  output logic [dataWidth-1:0]   exAluB,
  output logic                   exUpdFlag,
  output logic                   exUpdP0,
  output logic                   exUpdP1,
  output mslOpT                  exMslOp,
  output logic [dataWidth-1:0]   exMslA,
  output logic [dataWidth-1:0]   exMslB,
  output logic                   exIsMul,
  output logic                   exIsShift
);

  // Predicated controls
  logic  gRfWe;
  aluOpT gAluOp;
  logic  gIsAlu;
  mslOpT gMslOp;
  logic  gIsMsl;
  logic  gIsMul;
  logic  gIsShift;

  // ********************************************************
  // Predicate check for the whole stage
  // ********************************************************
  predicateGate predicateGate_i (
    .predCode (predCode), .p0 (p0), .p1 (p1),
    .rfWe     (rfWe),
    .aluOp    (aluOp),    .isAlu  (isAlu),
    .mslOp    (mslOp),    .isMsl  (isMsl),
    .isMul    (isMul),    .isShift (isShift),
    .gRfWe    (gRfWe),
    .gAluOp   (gAluOp),   .gIsAlu (gIsAlu),
    .gMslOp   (gMslOp),   .gIsMsl (gIsMsl),
    .gIsMul   (gIsMul),   .gIsShift (gIsShift)
  );

  // ********************************************************
  // Issue registers
  // ********************************************************
  writebackReg #(.rfIndexWidth(rfIndexWidth)) writebackReg_i (
    .iClk (iClk), .rstN (rstN),
    .gRfWe (gRfWe), .rfAddr (rfAddr), .wbSrc (wbSrc),
    .exWbEn (exWbEn), .exRfAddr (exRfAddr), .exWbSrc (exWbSrc)
  );

  aluIssue #(.dataWidth(dataWidth)) aluIssue_i (
    .iClk (iClk), .rstN (rstN),
    .gIsAlu (gIsAlu), .gAluOp (gAluOp), .updSel (updSel),
    .opA (opA), .opB (opB),
    .exAluOp (exAluOp), .exAluA (exAluA), .exAluB (exAluB),
    .exUpdFlag (exUpdFlag), .exUpdP0 (exUpdP0), .exUpdP1 (exUpdP1),
    .isSub (isSub)  // Combinational in the same cycle
  );

  mslIssue #(.dataWidth(dataWidth)) mslIssue_i (
    .iClk (iClk), .rstN (rstN),
    .gIsMsl (gIsMsl), .gMslOp (gMslOp),
    .gIsMul (gIsMul), .gIsShift (gIsShift),
    .opA (opA), .opB (opB),
    .exMslOp (exMslOp), .exMslA (exMslA), .exMslB (exMslB),
    .exIsMul (exIsMul), .exIsShift (exIsShift)
  );

endmodule

`default_nettype wire

//--- rtl/mslIssue.sv
// Multiply/shift/logic issue registers
// Captures operands, opcode and the multiply/shift kind bits for
// MSL instructions only; holds them otherwise to keep EX inputs quiet
`timescale 1ns/100ps
`default_nettype none

module mslIssue
  import peDecodePkg::*;
#(
  parameter int dataWidth = 24
)
(
  input  wire                  iClk,
  input  wire                  rstN,
  input  wire                  gIsMsl,     // Predicated MSL instruction
  input  var mslOpT            gMslOp,
  input  wire                  gIsMul,
  input  wire                  gIsShift,
  input  wire [dataWidth-1:0]  opA,
  input  wire [dataWidth-1:0]  opB,
  output mslOpT                exMslOp,
  output logic [dataWidth-1:0] exMslA,
  output logic [dataWidth-1:0] exMslB,
  output logic                 exIsMul,    // Kind bits for EX
  output logic                 exIsShift
);

  // ********************************************************
  // Kind bits
  // ********************************************************
  // Logic ops load both as 0
  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
    begin
      exIsMul   <= 1'b0;
      exIsShift <= 1'b0;
    end
    else if (gIsMsl)
    begin
      exIsMul   <= gIsMul;
      exIsShift <= gIsShift;
    end
  end

  // ********************************************************
  // Operands and opcode
  // ********************************************************
  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
    begin
      exMslOp <= mslNop;
      exMslA  <= '0;
      exMslB  <= '0;
    end
    else if (gIsMsl)  // Unchanged across ALU-only cycles
    begin
      exMslOp <= gMslOp;
      exMslA  <= opA;
      exMslB  <= opB;
    end
  end

endmodule

`default_nettype wire

//--- rtl/aluIssue.sv
// ALU issue registers
// Captures add/sub/compare operands and opcode, routes the compare
// result to flag, P0 or P1, and flags a subtract to the bypass network
`timescale 1ns/100ps
`default_nettype none

module aluIssue
  import peDecodePkg::*;
#(
  parameter int dataWidth = 24
)
(
  input  wire                  iClk,
  input  wire                  rstN,
  input  wire                  gIsAlu,    // Predicated ALU instruction
  input  var aluOpT            gAluOp,
  input  var updSelT           updSel,
  input  wire [dataWidth-1:0]  opA,       // From bypass network
  input  wire [dataWidth-1:0]  opB,
  output aluOpT                exAluOp,
  output logic [dataWidth-1:0] exAluA,
  output logic [dataWidth-1:0] exAluB,
  output logic                 exUpdFlag,
  output logic                 exUpdP0,
  output logic                 exUpdP1,
  output logic                 isSub      // Same cycle, to bypass
);

  logic updFlagD;
  logic updP0D;
  logic updP1D;

  // ********************************************************
  // Compare-result routing
  // ********************************************************
  always_comb
  begin
    updFlagD = 1'b0;
    updP0D   = 1'b0;
    updP1D   = 1'b0;
    case (updSel)
      updP0:   updP0D   = gIsAlu;
      updP1:   updP1D   = gIsAlu;
      default: updFlagD = gIsAlu;  // updFlag and the spare code
    endcase
  end

  // Update bits track every instruction
  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
    begin
      exUpdFlag <= 1'b0;
      exUpdP0   <= 1'b0;
      exUpdP1   <= 1'b0;
    end
    else
    begin
      exUpdFlag <= updFlagD;
      exUpdP0   <= updP0D;
      exUpdP1   <= updP1D;
    end
  end

  // ********************************************************
  // Operand and opcode registers
  // ********************************************************
  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
    begin
      exAluOp <= aluNop;
      exAluA  <= '0;
      exAluB  <= '0;
    end
    else if (gIsAlu)  // Hold between ALU instructions
    begin
      exAluOp <= gAluOp;
      exAluA  <= opA;
      exAluB  <= opB;
    end
  end

  // Squashed opcode is nop, so a predicated-off sub never shows
  assign isSub = (gAluOp == aluSub);

endmodule

`default_nettype wire

//--- rtl/writebackReg.sv
// Register-file write-back pipeline registers
// Suppresses writes to R0 and holds the address and source select
// between effective writes
`timescale 1ns/100ps
`default_nettype none

module writebackReg
  import peDecodePkg::*;
#(
  parameter int rfIndexWidth = 4
)
(
  input  wire                    iClk,
  input  wire                    rstN,
  input  wire                    gRfWe,     // Predicated write enable
  input  wire [rfIndexWidth-1:0] rfAddr,
  input  var wbSrcT              wbSrc,
  output logic                   exWbEn,
  output logic [rfIndexWidth-1:0] exRfAddr,
  output wbSrcT                  exWbSrc
);

  logic wrEff;  // Write that really lands

  // R0 reads as zero, so a write there is dropped
  assign wrEff = gRfWe & (|rfAddr);

  // ********************************************************
  // Pipeline registers
  // ********************************************************
  // Enable follows every instruction
  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
      exWbEn <= 1'b0;
    else
      exWbEn <= wrEff;
  end

  // Index and source only move on a real write
  always_ff @(posedge iClk or negedge rstN)
  begin
    if (!rstN)
    begin
      exRfAddr <= '0;
      exWbSrc  <= srcAlu;
    end
    else if (wrEff)
    begin
      exRfAddr <= rfAddr;  // Held otherwise
      exWbSrc  <= wbSrc;
    end
  end

endmodule

`default_nettype wire

//--- rtl/predicateGate.sv
// Predicate gate
// Checks the two-bit predicate code against P0/P1 and squashes the
// instruction's enables and opcodes when the predicate fails
`timescale 1ns/100ps
`default_nettype none

module predicateGate
  import peDecodePkg::*;
(
  input  var predT  predCode,  // From first decode half
  input  wire       p0,        // Predicate regs from EX
  input  wire       p1,
  input  wire       rfWe,
  input  var aluOpT aluOp,
  input  wire       isAlu,
  input  var mslOpT mslOp,
  input  wire       isMsl,
  input  wire       isMul,
  input  wire       isShift,
  output logic      gRfWe,     // Squashed controls
  output aluOpT     gAluOp,
  output logic      gIsAlu,
  output mslOpT     gMslOp,
  output logic      gIsMsl,
  output logic      gIsMul,
  output logic      gIsShift
);

  logic insValid;  // Instruction executes

  // ********************************************************
  // Predicate decode
  // ********************************************************
  always_comb
  begin
    case (predCode)
      predAlways: insValid = 1'b1;
      predOnP0:   insValid = p0;
      predOnP1:   insValid = p1;
      predOnBoth: insValid = p0 & p1;
      default:    insValid = 1'b1;
    endcase
  end

  // Squash drives enables low and opcodes to nop
  assign gRfWe    = insValid & rfWe;
  assign gIsAlu   = insValid & isAlu;
  assign gIsMsl   = insValid & isMsl;
  assign gIsMul   = insValid & isMul;
  assign gIsShift = insValid & isShift;
  assign gAluOp   = insValid ? aluOp : aluNop;
  assign gMslOp   = insValid ? mslOp : mslNop;

endmodule

`default_nettype wire

//--- rtl/peDecodePkg.sv
// PE instruction-decode package
// Opcode, predicate, write-back source and update-select encodings,
// plus the default widths for the PE datapath
`default_nettype none

package peDecodePkg;

  // ********************************************************
  // Default widths
  // ********************************************************
  parameter int defDataWidth    = 24;  // PE datapath
  parameter int defRfIndexWidth = 4;   // 16 registers with R0 hard-wired zero

  // ********************************************************
  // Encodings
  // ********************************************************
  // ALU add/sub/compare ops with nop when squashed
  typedef enum logic [2:0] {
    aluNop   = 3'd0,
    aluAdd   = 3'd1,
    aluSub   = 3'd2,
    aluCmpEq = 3'd3,
    aluCmpLt = 3'd4
  } aluOpT;

  // Multiply/shift/logic unit
  typedef enum logic [2:0] {
    mslNop = 3'd0,
    mslMul = 3'd1,
    mslShl = 3'd2,
    mslShr = 3'd3,
    mslAnd = 3'd4,
    mslOr  = 3'd5,
    mslXor = 3'd6
  } mslOpT;

  typedef enum logic [1:0] {
    predAlways = 2'd0,  // Unconditional
    predOnP0   = 2'd1,
    predOnP1   = 2'd2,
    predOnBoth = 2'd3   // P0 and P1
  } predT;

  // Write-back data source
  typedef enum logic [1:0] {
    srcAlu = 2'd0,
    srcLr  = 2'd1,  // Link register
    srcLsu = 2'd2,
    srcMul = 2'd3
  } wbSrcT;

  // Compare-result destination
  typedef enum logic [1:0] {
    updFlag = 2'd0,
    updP0   = 2'd1,
    updP1   = 2'd2,
    updRsvd = 2'd3   // Unused code treated as flag
  } updSelT;

endpackage

`default_nettype wire
